/* regexPkg.sv */
// Regex matcher definitions
`default_nettype none

package regexPkg;

    // Sizes of the engine.
    localparam int PcWidth      = 5;
    localparam int ProgDepth    = 32;
    localparam int CharWidth    = 8;
    localparam int DataWidth    = 8;
    localparam int ListDepth    = 32;
    localparam int ListPtrWidth = $clog2(ListDepth);
    localparam int ListCntWidth = $clog2(ListDepth + 1);

    typedef logic [PcWidth-1:0]   Pc;
    typedef logic [CharWidth-1:0] Char;

    typedef enum logic [2:0] {
        ACCEPT                = 3'd0,
        ACCEPT_PARTIAL        = 3'd1,
        SPLIT                 = 3'd2,
        MATCH                 = 3'd3,
        MATCH_ANY             = 3'd4,
        JMP                   = 3'd5,
        END_WITHOUT_ACCEPTING = 3'd6
    } OpCode;

    // Data holds a character for MATCH and a target PC in its low bits.
    typedef struct packed {
        OpCode                op;
        logic [DataWidth-1:0] data;
    } Instr;

    // A continuation PC and the list it belongs to.
    typedef struct packed {
        Pc    pc;
        logic toCurrent;
    } Thread;

    // Contents of a slot that was never written.
    localparam Instr KillInstr = '{op: END_WITHOUT_ACCEPTING, data: '0};

endpackage

`default_nettype wire

/* pcList.sv */
// Program counter FIFO
`timescale 1ns/10ps
`default_nettype none

module pcList (
    input  wire             clk,
    input  wire             rst,
    input  wire             push,
    input  wire regexPkg::Pc pushPc,
    input  wire             pop,
    output regexPkg::Pc     popPc,
    output logic            empty,
    output logic            full,
    input  wire             clear
);
    import regexPkg::*;

    Pc                       slots [ListDepth];
    logic [ListPtrWidth-1:0] wrPtr;
    logic [ListPtrWidth-1:0] rdPtr;
    logic [ListCntWidth-1:0] count;

    // A push in the clearing cycle lands in slot zero.
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            slots[clear ? '0 : wrPtr] <= pushPc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else if (clear)
        begin
            rdPtr <= '0;
            wrPtr <= push ? ListPtrWidth'(1) : '0;
            count <= push ? ListCntWidth'(1) : '0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    assign popPc = slots[rdPtr];
    assign empty = (count == '0);
    assign full  = (count == ListCntWidth'(ListDepth));

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(push && full && !clear));
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty && !clear));

endmodule

`default_nettype wire

/* progStore.sv */
// Regex program store
`timescale 1ns/10ps
`default_nettype none

module progStore (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 progWe,
    input  wire regexPkg::Pc    progAddr,
    input  wire regexPkg::Instr progData,
    input  wire                 memValid,
    input  wire regexPkg::Pc    memAddr,
    output logic                memReady,
    output regexPkg::Instr      memData
);
    import regexPkg::*;

    Instr                 slots [ProgDepth];
    logic [ProgDepth-1:0] slotWritten;

    always_ff @(posedge clk)
    begin
        if (progWe)
        begin
            slots[progAddr] <= progData;
        end
    end

    // Tracks which slots hold a host-written instruction.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slotWritten <= '0;
        end
        else if (progWe)
        begin
            slotWritten[progAddr] <= 1'b1;
        end
    end

    // The host write owns the port in its cycle.
    assign memReady = !progWe;

    always_ff @(posedge clk)
    begin
        if (memValid && memReady)
        begin
            memData <= slotWritten[memAddr] ? slots[memAddr] : KillInstr;
        end
    end

endmodule

`default_nettype wire

/* regexCpu.sv */
// Pike VM thread executor
`timescale 1ns/10ps
`default_nettype none

module regexCpu (
    input  wire                 clk,
    input  wire                 rst,
    input  wire regexPkg::Char  curChar,
    input  wire                 inPcValid,
    input  wire regexPkg::Pc    inPc,
    output logic                inPcReady,
    output logic                memValid,
    output regexPkg::Pc         memAddr,
    input  wire                 memReady,
    input  wire regexPkg::Instr memData,
    output logic                outValid,
    output regexPkg::Thread     outThread,
    input  wire                 outReady,
    output logic                cpuAccept
);
    import regexPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_SEND,
        FETCH_REC,
        EXEC_1,
        EXEC_2
    } State;

    State  state;
    State  stateNext;
    Pc     curPc;
    Instr  curInstr;
    Pc     pcPlusOne;
    Pc     targetPc;
    logic  inExec;
    logic  execValid;
    logic  execAccept;
    Thread execThread;
    State  execNext;

    assign pcPlusOne = curPc + 1'b1;
    assign targetPc  = curInstr.data[PcWidth-1:0];
    assign inExec    = (state == EXEC_1) || (state == EXEC_2);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && inPcValid)
        begin
            curPc <= inPc;
        end
        if (state == FETCH_REC)
        begin
            curInstr <= memData;
        end
    end

    // Continuations and accept for the latched instruction.
    always_comb
    begin
        execValid  = 1'b0;
        execAccept = 1'b0;
        execThread = '{pc: pcPlusOne, toCurrent: 1'b1};
        execNext   = IDLE;
        case (curInstr.op)
            ACCEPT:
            begin
                execAccept = (curChar == '0);
            end
            ACCEPT_PARTIAL:
            begin
                execAccept = 1'b1;
            end
            SPLIT:
            begin
                execValid = 1'b1;
                if (state == EXEC_1)
                begin
                    execNext = EXEC_2;
                end
                else
                begin
                    execThread.pc = targetPc;
                end
            end
            MATCH:
            begin
                if (curChar == curInstr.data)
                begin
                    execValid            = 1'b1;
                    execThread.toCurrent = 1'b0;
                end
            end
            MATCH_ANY:
            begin
                execValid            = 1'b1;
                execThread.toCurrent = 1'b0;
            end
            JMP:
            begin
                execValid     = 1'b1;
                execThread.pc = targetPc;
            end
            default:
            begin
                // Thread dies.
            end
        endcase
    end

    always_comb
    begin
        inPcReady = (state == IDLE);
        memValid  = (state == FETCH_SEND);
        memAddr   = curPc;
        outValid  = inExec && execValid;
        outThread = execThread;
        cpuAccept = inExec && execAccept;
        stateNext = state;
        case (state)
            IDLE:
            begin
                if (inPcValid)
                begin
                    stateNext = FETCH_SEND;
                end
            end
            FETCH_SEND:
            begin
                if (memReady)
                begin
                    stateNext = FETCH_REC;
                end
            end
            FETCH_REC:
            begin
                stateNext = EXEC_1;
            end
            EXEC_1, EXEC_2:
            begin
                // Hold the continuation until the sequencer takes it.
                if (!execValid || outReady)
                begin
                    stateNext = execNext;
                end
            end
            default:
            begin
                stateNext = IDLE;
            end
        endcase
    end

    // A stalled continuation stays on offer unchanged.
    outHeldUntilTaken: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outThread)));

endmodule

`default_nettype wire

/* matchSequencer.sv */
// Thread list sequencer
`timescale 1ns/10ps
`default_nettype none

module matchSequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire regexPkg::Pc     startPc,
    input  wire regexPkg::Char   curChar,
    output logic                 charTake,
    output logic                 busy,
    output logic                 done,
    output logic                 matched,
    output logic                 inPcValid,
    output regexPkg::Pc          inPc,
    input  wire                  inPcReady,
    input  wire                  outValid,
    input  wire regexPkg::Thread outThread,
    output logic                 outReady,
    input  wire                  cpuAccept,
    output logic                 pushA,
    output regexPkg::Pc          pushPcA,
    output logic                 popA,
    input  wire regexPkg::Pc     popPcA,
    input  wire                  emptyA,
    input  wire                  fullA,
    output logic                 clearA,
    output logic                 pushB,
    output regexPkg::Pc          pushPcB,
    output logic                 popB,
    input  wire regexPkg::Pc     popPcB,
    input  wire                  emptyB,
    input  wire                  fullB,
    output logic                 clearB
);
    import regexPkg::*;

    // listSel low means list A is the current list.
    logic                 listSel;
    logic [ProgDepth-1:0] visitedCur;
    logic [ProgDepth-1:0] visitedNext;
    logic                 startRun;
    logic                 curEmpty;
    logic                 nextEmpty;
    logic                 destFull;
    logic                 isDup;
    logic                 pushCur;
    logic                 pushNext;
    logic                 stepEnd;
    logic                 runEnd;
    Pc                    outPc;

    assign startRun  = start && !busy;
    assign curEmpty  = listSel ? emptyB : emptyA;
    assign nextEmpty = listSel ? emptyA : emptyB;
    assign outPc     = outThread.pc;

    assign inPcValid = busy && !curEmpty;
    assign inPc      = listSel ? popPcB : popPcA;

    // Threads already seen for their list are taken and dropped.
    assign isDup    = outThread.toCurrent ? visitedCur[outPc] : visitedNext[outPc];
    assign destFull = (outThread.toCurrent ^ listSel) ? fullA : fullB;
    assign outReady = isDup || !destFull;
    assign pushCur  = outValid && outReady && !isDup && outThread.toCurrent;
    assign pushNext = outValid && outReady && !isDup && !outThread.toCurrent;

    assign pushA   = listSel ? pushNext : (startRun || pushCur);
    assign pushB   = listSel ? (startRun || pushCur) : pushNext;
    assign pushPcA = startRun ? startPc : outPc;
    assign pushPcB = startRun ? startPc : outPc;
    assign popA    = inPcValid && inPcReady && !listSel;
    assign popB    = inPcValid && inPcReady && listSel;
    assign clearA  = startRun;
    assign clearB  = startRun;

    // All threads for this character have run.
    assign stepEnd = busy && !cpuAccept && curEmpty && inPcReady;
    assign runEnd  = nextEmpty || (curChar == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy        <= 1'b0;
            done        <= 1'b0;
            matched     <= 1'b0;
            charTake    <= 1'b0;
            listSel     <= 1'b0;
            visitedCur  <= '0;
            visitedNext <= '0;
        end
        else
        begin
            done     <= 1'b0;
            charTake <= 1'b0;
            if (startRun)
            begin
                busy        <= 1'b1;
                matched     <= 1'b0;
                visitedCur  <= ProgDepth'(1) << startPc;
                visitedNext <= '0;
            end
            else if (busy && cpuAccept)
            begin
                busy    <= 1'b0;
                done    <= 1'b1;
                matched <= 1'b1;
            end
            else if (stepEnd && runEnd)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            else if (stepEnd)
            begin
                listSel     <= !listSel;
                charTake    <= 1'b1;
                visitedCur  <= visitedNext;
                visitedNext <= '0;
            end
            else
            begin
                if (pushCur)
                begin
                    visitedCur[outPc] <= 1'b1;
                end
                if (pushNext)
                begin
                    visitedNext[outPc] <= 1'b1;
                end
            end
        end
    end

    // A new character always starts with threads to run.
    takeHasThreads: assert property (@(posedge clk) disable iff (rst)
        charTake |-> !curEmpty);

endmodule

`default_nettype wire

/* regexTop.sv */
// Regex matcher top level
`timescale 1ns/10ps
`default_nettype none

module regexTop (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 progWe,
    input  wire regexPkg::Pc    progAddr,
    input  wire regexPkg::Instr progData,
    input  wire                 start,
    input  wire regexPkg::Pc    startPc,
    input  wire regexPkg::Char  curChar,
    output logic                charTake,
    output logic                busy,
    output logic                done,
    output logic                matched
);
    import regexPkg::*;

    logic  inPcValid;
    Pc     inPc;
    logic  inPcReady;
    logic  memValid;
    Pc     memAddr;
    logic  memReady;
    Instr  memData;
    logic  outValid;
    Thread outThread;
    logic  outReady;
    logic  cpuAccept;
    logic  pushA;
    Pc     pushPcA;
    logic  popA;
    Pc     popPcA;
    logic  emptyA;
    logic  fullA;
    logic  clearA;
    logic  pushB;
    Pc     pushPcB;
    logic  popB;
    Pc     popPcB;
    logic  emptyB;
    logic  fullB;
    logic  clearB;

    progStore store (.clk, .rst, .progWe, .progAddr, .progData,
                     .memValid, .memAddr, .memReady, .memData);

    regexCpu cpu (.clk, .rst, .curChar, .inPcValid, .inPc, .inPcReady,
                  .memValid, .memAddr, .memReady, .memData,
                  .outValid, .outThread, .outReady, .cpuAccept);

    matchSequencer seq (.clk, .rst, .start, .startPc, .curChar, .charTake, .busy, .done,
                        .matched, .inPcValid, .inPc, .inPcReady, .outValid, .outThread,
                        .outReady, .cpuAccept,
                        .pushA, .pushPcA, .popA, .popPcA, .emptyA, .fullA, .clearA,
                        .pushB, .pushPcB, .popB, .popPcB, .emptyB, .fullB, .clearB);

    pcList listA (.clk, .rst, .push(pushA), .pushPc(pushPcA), .pop(popA), .popPc(popPcA),
                  .empty(emptyA), .full(fullA), .clear(clearA));

    pcList listB (.clk, .rst, .push(pushB), .pushPc(pushPcB), .pop(popB), .popPc(popPcB),
                  .empty(emptyB), .full(fullB), .clear(clearB));

endmodule

`default_nettype wire

/* regexTb.sv */
// Regex matcher testbench
`timescale 1ns/10ps
`default_nettype none

module regexTb;
    import regexPkg::*;

    localparam int RunTimeout  = 2000;
    localparam int IdleTimeout = 2000;
    localparam int RandomRuns  = 12;

    logic clk = 1'b0;
    logic rst;
    logic progWe;
    Pc    progAddr;
    Instr progData;
    logic start;
    Pc    startPc;
    Char  curChar;
    logic charTake;
    logic busy;
    logic done;
    logic matched;

    logic  expectMatch;
    logic  hung;
    int    errCount;
    int    testsPassed;
    int    testsFailed;
    int    testErrStart;
    Instr  progQ [$];
    string textBuf;
    int    textIdx;

    regexTop uut (.clk, .rst, .progWe, .progAddr, .progData, .start, .startPc,
                  .curChar, .charTake, .busy, .done, .matched);

    always #2 clk = ~clk;

    // The run result must agree with the regex meaning of the text.
    matchedAtDone: assert property (@(posedge clk) disable iff (rst)
        done |-> (matched == expectMatch))
    else
    begin
        $display("MISMATCH matched: got 0x%h, expected 0x%h",
                 $sampled(matched), $sampled(expectMatch));
        errCount++;
    end

    // Done ends a run, so busy was high just before.
    doneAfterBusy: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy))
    else
    begin
        $display("Done pulsed although the matcher had not been busy");
        errCount++;
    end

    function automatic Instr encode(OpCode op, logic [7:0] data);
        Instr ins;
        ins.op   = op;
        ins.data = data;
        return ins;
    endfunction

    function automatic void addInstr(OpCode op, logic [7:0] data);
        progQ.push_back(encode(op, data));
    endfunction

    // Characters past the end of the text read as zero.
    function automatic Char charAt(int idx);
        if (idx < textBuf.len())
        begin
            return Char'(textBuf[idx]);
        end
        return '0;
    endfunction

    function automatic logic endsInB(string text);
        if (text.len() == 0)
        begin
            return 1'b0;
        end
        return (text[text.len() - 1] == "b");
    endfunction

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IdleTimeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (busy)
        begin
            hung = 1'b1;
            $display("Timeout: busy stayed high for %0d cycles", IdleTimeout);
        end
    endtask

    // Writes the queued program and fills the other slots with kill instructions.
    task automatic loadProgram();
        if (hung)
        begin
            return;
        end
        waitIdle();
        for (int addr = 0; addr < ProgDepth; addr++)
        begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = Pc'(addr);
            if (addr < progQ.size())
            begin
                progData = progQ[addr];
            end
            else
            begin
                progData = encode(END_WITHOUT_ACCEPTING, 8'(addr));
            end
        end
        @(negedge clk);
        progWe = 1'b0;
        progQ.delete();
    endtask

    task automatic runText(input string text, input logic expected);
        int   cycles;
        logic seenDone;
        if (hung)
        begin
            return;
        end
        waitIdle();
        textBuf = text;
        textIdx = 0;
        @(negedge clk);
        expectMatch = expected;
        curChar     = charAt(0);
        startPc     = '0;
        start       = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        cycles   = 0;
        seenDone = 1'b0;
        // Feed one character per charTake until done.
        while (!seenDone && cycles < RunTimeout)
        begin
            @(negedge clk);
            cycles++;
            if (done)
            begin
                seenDone = 1'b1;
            end
            else if (charTake)
            begin
                textIdx++;
                curChar = charAt(textIdx);
            end
        end
        if (!seenDone)
        begin
            hung = 1'b1;
            $display("Timeout: no done within %0d cycles for text \"%s\"", RunTimeout, text);
        end
        else
        begin
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input int num, input string name);
        if (!hung && errCount == testErrStart)
        begin
            testsPassed++;
            $display("Test %0d (%s): pass", num, name);
        end
        else
        begin
            testsFailed++;
            $display("Test %0d (%s): fail", num, name);
        end
        testErrStart = errCount;
    endtask

    task automatic literalTest();
        addInstr(MATCH, "a");
        addInstr(MATCH, "b");
        addInstr(ACCEPT, 8'd0);
        loadProgram();
        runText("ab", 1'b1);
        runText("ac", 1'b0);
        runText("abc", 1'b0);
        reportTest(1, "literal ab");
    endtask

    task automatic alternationTest();
        addInstr(SPLIT, 8'd3);
        addInstr(MATCH, "a");
        addInstr(JMP, 8'd4);
        addInstr(MATCH, "b");
        addInstr(ACCEPT, 8'd0);
        loadProgram();
        runText("a", 1'b1);
        runText("b", 1'b1);
        runText("c", 1'b0);
        reportTest(2, "alternation a|b");
    endtask

    task automatic starTest();
        // a* written as (a?)*, so the loop body can also be empty.
        addInstr(SPLIT, 8'd4);
        addInstr(SPLIT, 8'd3);
        addInstr(MATCH, "a");
        addInstr(JMP, 8'd0);
        addInstr(ACCEPT, 8'd0);
        loadProgram();
        runText("", 1'b1);
        runText("aaaa", 1'b1);
        runText("ab", 1'b0);
        reportTest(3, "star a*");
    endtask

    task automatic partialTest();
        addInstr(MATCH_ANY, 8'd0);
        addInstr(ACCEPT_PARTIAL, 8'd0);
        loadProgram();
        runText("xq", 1'b1);
        // Falling through the killed branch would reach an accept at 2.
        addInstr(SPLIT, 8'd3);
        addInstr(END_WITHOUT_ACCEPTING, 8'd0);
        addInstr(ACCEPT_PARTIAL, 8'd0);
        addInstr(MATCH, "q");
        addInstr(ACCEPT_PARTIAL, 8'd0);
        loadProgram();
        runText("xq", 1'b0);
        runText("qx", 1'b1);
        reportTest(4, "any char and dead branch");
    endtask

    task automatic randomTest();
        string text;
        int    len;
        // Program for (a|b)*b.
        addInstr(SPLIT, 8'd6);
        addInstr(SPLIT, 8'd4);
        addInstr(MATCH, "a");
        addInstr(JMP, 8'd0);
        addInstr(MATCH, "b");
        addInstr(JMP, 8'd0);
        addInstr(MATCH, "b");
        addInstr(ACCEPT, 8'd0);
        loadProgram();
        for (int run = 0; run < RandomRuns; run++)
        begin
            text = "";
            len  = $urandom % 8;
            for (int i = 0; i < len; i++)
            begin
                if ($urandom % 2)
                begin
                    text = {text, "b"};
                end
                else
                begin
                    text = {text, "a"};
                end
            end
            runText(text, endsInB(text));
        end
        reportTest(5, "random (a|b)*b");
    endtask

    task automatic reloadTest();
        addInstr(MATCH, "a");
        addInstr(MATCH, "b");
        addInstr(ACCEPT, 8'd0);
        loadProgram();
        runText("ab", 1'b1);
        addInstr(MATCH, "a");
        addInstr(MATCH, "c");
        addInstr(ACCEPT, 8'd0);
        loadProgram();
        runText("ab", 1'b0);
        runText("ac", 1'b1);
        reportTest(6, "program reload");
    endtask

    initial
    begin
        void'($urandom(39930));
        rst          = 1'b1;
        progWe       = 1'b0;
        progAddr     = '0;
        progData     = '0;
        start        = 1'b0;
        startPc      = '0;
        curChar      = '0;
        expectMatch  = 1'b0;
        hung         = 1'b0;
        errCount     = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        testErrStart = 0;
        textBuf      = "";
        textIdx      = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        literalTest();
        if (!hung)
        begin
            alternationTest();
        end
        if (!hung)
        begin
            starTest();
        end
        if (!hung)
        begin
            partialTest();
        end
        if (!hung)
        begin
            randomTest();
        end
        if (!hung)
        begin
            reloadTest();
        end
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 testsPassed, testsFailed, errCount);
        if (hung || testsFailed != 0 || errCount != 0)
        begin
            $display("Result: FAILED");
        end
        else
        begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
regexPkg.sv
pcList.sv
progStore.sv
regexCpu.sv
matchSequencer.sv
regexTop.sv
regexTb.sv

/* Bender.yml */
package:
  name: regex_matcher

sources:
  - regexPkg.sv
  - pcList.sv
  - progStore.sv
  - regexCpu.sv
  - matchSequencer.sv
  - regexTop.sv
  - target: test
    files:
      - regexTb.sv
